/* test/vec_alu_stimulus.txt */
# Columns: op x0 x1 x2 y0 y1 y2 r0 r1 r2 in hex, lane 0 first, Q16.16 numbers
# op 0 add, 1 scale (scalar in y0), 2 dot (result in r0, r1 r2 zero), 3 cross
0 00010000 00020000 00030000 00008000 00004000 FFFF0000 00018000 00024000 00020000
0 7FFFFFFF 80000000 12345678 00000001 FFFFFFFF 11111111 80000000 7FFFFFFF 23456789
0 FFFF8000 00000000 7FFF0000 00008000 00000000 00020000 00000000 00000000 80010000
0 00000000 00000000 00000000 0A0B0C0D F0F0F0F0 00000003 0A0B0C0D F0F0F0F0 00000003
1 00010000 00020000 FFFD0000 00028000 00000000 00000000 00028000 00050000 FFF88000
1 00030000 FFFF0000 00008000 FFFF8000 00000000 00000000 FFFE8000 00008000 FFFFC000
1 00000001 FFFFFFFF 00000003 00008000 00000000 00000000 00000000 FFFFFFFF 00000001
1 7FFF0000 00010000 00000000 00020000 00000000 00000000 FFFE0000 00020000 00000000
1 00010000 00010000 00010000 00004000 DEADBEEF 12345678 00004000 00004000 00004000
2 00010000 00020000 00030000 00040000 00050000 00060000 00200000 00000000 00000000
2 00010000 FFFF0000 00020000 00030000 00020000 FFFF0000 FFFF0000 00000000 00000000
2 FFFFFFFF FFFFFFFF FFFFFFFF 00008000 00008000 00008000 FFFFFFFD 00000000 00000000
2 00018000 00004000 00000000 00018000 00040000 7FFFFFFF 00034000 00000000 00000000
2 00010000 00000000 00000000 00000000 00010000 00000000 00000000 00000000 00000000
3 00010000 00000000 00000000 00000000 00010000 00000000 00000000 00000000 00010000
3 00000000 00010000 00000000 00000000 00000000 00010000 00010000 00000000 00000000
3 00000000 00000000 00010000 00010000 00000000 00000000 00000000 00010000 00000000
3 00000000 00010000 00000000 00010000 00000000 00000000 00000000 00000000 FFFF0000
3 00010000 FFFE0000 00030000 FFFC0000 00050000 FFFA0000 FFFD0000 FFFA0000 FFFD0000
3 00008000 FFFE8000 00020000 00020000 00004000 FFFF0000 00010000 00048000 00032000
3 00000001 FFFFFFFF 00000000 00004000 00008000 00010000 FFFFFFFF FFFFFFFF 00000000
3 00020000 00030000 00040000 00050000 00060000 00070000 FFFD0000 00060000 FFFD0000
0 00001234 FFFFEDCC 40000000 00000766 00001000 40000000 0000199A FFFFFDCC 80000000
2 00028000 FFFE0000 00010000 00020000 00018000 FFFF8000 00018000 00000000 00000000
1 12345678 87654321 00000000 00010000 00000000 00000000 12345678 87654321 00000000
3 00010000 00020000 00030000 00020000 00040000 00060000 00000000 00000000 00000000

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the vector unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module vec_alu_tb -f sources.f -o vec_alu_sim > build.log 2>&1 \
    && ./obj_dir/vec_alu_sim > "$LOG" 2>&1 \
    || { cat build.log "$LOG" 2>/dev/null; echo "Build or simulation run failed"; exit 1; }

cat "$LOG"
grep -qF "*** TEST FAILED ***" "$LOG" && exit 1 || exit 0

/* sources.f */
verilog/vec_fixed_pkg.sv
verilog/vec_cmd_pkg.sv
verilog/sync_fifo.sv
verilog/vec_elementwise.sv
verilog/vec_products.sv
verilog/vec_op_control.sv
verilog/vec_alu_top.sv
test/vec_alu_tb.sv

/* test/vec_alu_tb.sv */
// Testbench for the vector arithmetic unit that replays the command file with back-pressure
module vec_alu_tb
    import vec_fixed_pkg::*;
    import vec_cmd_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int    HALF_PERIOD = 20;
    localparam int    WAIT_LIMIT  = 2000;
    localparam string STIM_FILE   = "test/vec_alu_stimulus.txt";

    logic         clock;
    logic         reset;
    vec_op_e      cmd_op;
    vec3_t        cmd_x;
    vec_operand_u cmd_y;
    logic         cmd_wr_en;
    logic         cmd_full;
    vec_operand_u res_data;
    logic         res_empty;
    logic         res_rd_en;

    // One entry per command line of the file
    logic [1:0]   op_q  [$];
    vec3_t        x_q   [$];
    vec3_t        y_q   [$];
    vec3_t        exp_q [$];

    int           error_count;
    int           check_count;
    logic         saw_full;
    logic         timed_out;
    integer       seed;

    vec_alu_top vec_alu_top_i (
        .clock     (clock),
        .reset     (reset),
        .cmd_op    (cmd_op),
        .cmd_x     (cmd_x),
        .cmd_y     (cmd_y),
        .cmd_wr_en (cmd_wr_en),
        .cmd_full  (cmd_full),
        .res_data  (res_data),
        .res_empty (res_empty),
        .res_rd_en (res_rd_en)
    );

    initial begin
        clock = 1'b0;
        forever #(HALF_PERIOD) clock = ~clock;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("[FAIL] %0d ns %s expected %h actual %h", $time, name, expected, actual);
        end
    endtask

    task automatic load_stimulus();
        int          fd;
        int          fields;
        string       line;
        logic [31:0] v [10];
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("ERROR: could not open the stimulus file %s", STIM_FILE);
            error_count++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line[0] != "#") begin
                fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h", v[0], v[1], v[2],
                                 v[3], v[4], v[5], v[6], v[7], v[8], v[9]);
                if (fields == 10) begin
                    op_q.push_back(v[0][1:0]);
                    x_q.push_back({v[3], v[2], v[1]});
                    y_q.push_back({v[6], v[5], v[4]});
                    exp_q.push_back({v[9], v[8], v[7]});
                end else begin
                    $display("ERROR: a stimulus line has %0d fields instead of 10", fields);
                    error_count++;
                end
            end
        end
        $fclose(fd);
        if (op_q.size() == 0) begin
            $display("ERROR: the stimulus file holds no commands");
            error_count++;
        end
    endtask

    task automatic write_commands();
        int waited;
        foreach (op_q[i]) begin
            waited = 0;
            @(negedge clock);
            while (cmd_full && waited < WAIT_LIMIT) begin
                saw_full  = 1'b1;
                cmd_wr_en = 1'b0;
                waited++;
                @(negedge clock);
            end
            if (cmd_full) begin
                $display("ERROR: cmd_full stayed high and command %0d was never written", i);
                error_count++;
                timed_out = 1'b1;
                cmd_wr_en = 1'b0;
                return;
            end
            cmd_op    = vec_op_e'(op_q[i]);
            cmd_x     = x_q[i];
            cmd_y     = y_q[i];
            cmd_wr_en = 1'b1;
        end
        @(negedge clock);
        cmd_wr_en = 1'b0;
    endtask

    task automatic compare_result(input int idx);
        // Dot lands in the scalar view
        if (op_q[idx] == OP_DOT) begin
            check_value("res_data.scalar.value", exp_q[idx][0], res_data.scalar.value);
            check_value("res_data.scalar.reserved[31:0]", 32'h0,
                        res_data.scalar.reserved[31:0]);
            check_value("res_data.scalar.reserved[63:32]", 32'h0,
                        res_data.scalar.reserved[63:32]);
        end else begin
            check_value("res_data.vec[0]", exp_q[idx][0], res_data.vec[0]);
            check_value("res_data.vec[1]", exp_q[idx][1], res_data.vec[1]);
            check_value("res_data.vec[2]", exp_q[idx][2], res_data.vec[2]);
        end
    endtask

    task automatic read_results(input logic hold_first, input logic random_stalls);
        int waited;
        int stall;
        waited = 0;
        while (hold_first && !saw_full && waited < WAIT_LIMIT) begin
            waited++;
            @(negedge clock);
        end
        if (hold_first && !saw_full) begin
            $display("ERROR: cmd_full never rose while the results were held back");
            error_count++;
        end
        @(negedge clock);
        foreach (exp_q[idx]) begin
            stall = random_stalls ? ($unsigned($random(seed)) % 4) : 0;
            repeat (stall) @(negedge clock);
            waited = 0;
            while (res_empty && waited < WAIT_LIMIT) begin
                waited++;
                @(negedge clock);
            end
            if (res_empty) begin
                $display("ERROR: results stopped arriving, result %0d of %0d never came",
                         idx, exp_q.size());
                error_count++;
                timed_out = 1'b1;
                return;
            end
            compare_result(idx);
            res_rd_en = 1'b1;
            @(negedge clock);
            res_rd_en = 1'b0;
        end
    endtask

    initial begin
        seed        = 32'h6d08;
        error_count = 0;
        check_count = 0;
        saw_full    = 1'b0;
        timed_out   = 1'b0;
        reset       = 1'b1;
        cmd_op      = OP_ADD;
        cmd_x       = '0;
        cmd_y       = '0;
        cmd_wr_en   = 1'b0;
        res_rd_en   = 1'b0;
        load_stimulus();
        repeat (16) @(negedge clock);
        reset = 1'b0;
        @(negedge clock);
        check_value("res_empty", 32'd1, 32'(res_empty));
        check_value("cmd_full", 32'd0, 32'(cmd_full));

        // Results held back until both FIFOs fill
        fork
            write_commands();
            read_results(1'b1, 1'b0);
        join
        repeat (4) @(negedge clock);
        check_value("res_empty", 32'd1, 32'(res_empty));

        if (!timed_out) begin
            saw_full = 1'b0;
            fork
                write_commands();
                read_results(1'b0, 1'b1);
            join
            repeat (4) @(negedge clock);
            check_value("res_empty", 32'd1, 32'(res_empty));
        end

        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* verilog/vec_alu_top.sv */
// Vector arithmetic unit with a command FIFO, two datapaths and a result FIFO
module vec_alu_top
    import vec_fixed_pkg::*;
    import vec_cmd_pkg::*;
(
    input  logic         clock,
    input  logic         reset,

    input  vec_op_e      cmd_op,
    input  vec3_t        cmd_x,
    input  vec_operand_u cmd_y,
    input  logic         cmd_wr_en,
    output logic         cmd_full,

    output vec_operand_u res_data,
    output logic         res_empty,
    input  logic         res_rd_en
);

    logic [CMD_BITS-1:0] cmd_head;
    vec_op_e             head_op;
    vec3_t               head_x;
    vec_operand_u        head_y;

    logic                in_empty;
    logic                in_rd_en;
    logic                out_full;
    logic                out_wr_en;

    vec3_t               sum;
    vec3_t               scaled;
    vec3_t               cross_prod;
    fix_t                dot;
    vec_operand_u        result;

    // Command word is opcode, then x, then y
    assign head_op = vec_op_e'(cmd_head[CMD_BITS-1 -: $bits(vec_op_e)]);
    assign head_x  = cmd_head[2*$bits(vec3_t)-1 -: $bits(vec3_t)];
    assign head_y  = cmd_head[$bits(vec3_t)-1:0];

    sync_fifo #(
        .WIDTH     (CMD_BITS),
        .DEPTH     (CMD_FIFO_DEPTH)
    ) u_cmd_fifo (
        .clock     (clock),
        .reset     (reset),
        .wr_en     (cmd_wr_en),
        .din       ({cmd_op, cmd_x, cmd_y}),
        .full      (cmd_full),
        .rd_en     (in_rd_en),
        .dout      (cmd_head),
        .empty     (in_empty)
    );

    vec_elementwise u_elementwise (
        .x         (head_x),
        .y         (head_y),
        .sum       (sum),
        .scaled    (scaled)
    );

    vec_products u_products (
        .x          (head_x),
        .y          (head_y.vec),
        .dot        (dot),
        .cross_prod (cross_prod)
    );

    vec_op_control u_control (
        .clock      (clock),
        .reset      (reset),
        .op         (head_op),
        .sum        (sum),
        .scaled     (scaled),
        .cross_prod (cross_prod),
        .dot        (dot),
        .in_empty   (in_empty),
        .in_rd_en   (in_rd_en),
        .result     (result),
        .out_full   (out_full),
        .out_wr_en  (out_wr_en)
    );

    sync_fifo #(
        .WIDTH     ($bits(vec_operand_u)),
        .DEPTH     (RES_FIFO_DEPTH)
    ) u_res_fifo (
        .clock     (clock),
        .reset     (reset),
        .wr_en     (out_wr_en),
        .din       (result),
        .full      (out_full),
        .rd_en     (res_rd_en),
        .dout      (res_data),
        .empty     (res_empty)
    );

endmodule

/* verilog/vec_op_control.sv */
// Sequencer that pops a command, registers the selected result and pushes it
module vec_op_control
    import vec_fixed_pkg::*;
    import vec_cmd_pkg::*;
(
    input  logic         clock,
    input  logic         reset,

    input  vec_op_e      op,
    input  vec3_t        sum,
    input  vec3_t        scaled,
    input  vec3_t        cross_prod,
    input  fix_t         dot,

    input  logic         in_empty,
    output logic         in_rd_en,

    output vec_operand_u result,
    input  logic         out_full,
    output logic         out_wr_en
);

    // Low is idle, high is holding a result for the output FIFO
    logic         holding;
    logic         holding_next;
    vec_operand_u selected;
    vec_operand_u result_next;

    // Result mux over the head command's opcode
    always_comb begin
        selected = '0;
        case (op)
            OP_ADD:   selected.vec = sum;
            OP_SCALE: selected.vec = scaled;
            // Reserved bits stay zero
            OP_DOT:   selected.scalar.value = dot;
            OP_CROSS: selected.vec = cross_prod;
        endcase
    end

    always_comb begin
        holding_next = holding;
        result_next  = result;
        in_rd_en     = 1'b0;
        out_wr_en    = 1'b0;

        if (!holding) begin
            if (!in_empty) begin
                in_rd_en     = 1'b1;
                result_next  = selected;
                holding_next = 1'b1;
            end
        end else if (!out_full) begin
            out_wr_en    = 1'b1;
            holding_next = 1'b0;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            holding <= 1'b0;
            result  <= '0;
        end else begin
            holding <= holding_next;
            result  <= result_next;
        end
    end

    // Command FIFO drains only through our pops
    a_empty_after_pop: assert property (
        @(posedge clock) disable iff (reset)
        $rose(in_empty) |-> $past(in_rd_en)
    ) else $error("vec_op_control: command FIFO emptied without a pop");

    // Result FIFO fills only through our pushes
    a_full_after_push: assert property (
        @(posedge clock) disable iff (reset)
        $rose(out_full) |-> $past(out_wr_en)
    ) else $error("vec_op_control: result FIFO filled without a push");

endmodule

/* verilog/vec_products.sv */
// Fixed-point dot and cross products of two 3-vectors
module vec_products
    import vec_fixed_pkg::*;
(
    input  vec3_t x,
    input  vec3_t y,
    output fix_t  dot,
    output vec3_t cross_prod
);

    logic signed [WIDE_BITS-1:0] lane_prod  [LANES];
    logic signed [WIDE_BITS-1:0] cross_wide [LANES];
    logic signed [WIDE_BITS-1:0] dot_acc;

    // Each lane product is shifted before the sum
    always_comb begin
        dot_acc = '0;
        for (int i = 0; i < LANES; i++) begin
            lane_prod[i] = wide_mul(x[i], y[i]);
            dot_acc      = dot_acc + (lane_prod[i] >>> Q_BITS);
        end
        dot = fix_t'(dot_acc);
    end

    // Difference taken at full width, then one shift per lane
    always_comb begin
        cross_wide[0] = wide_mul(x[1], y[2]) - wide_mul(x[2], y[1]);
        cross_wide[1] = wide_mul(x[2], y[0]) - wide_mul(x[0], y[2]);
        cross_wide[2] = wide_mul(x[0], y[1]) - wide_mul(x[1], y[0]);
        for (int i = 0; i < LANES; i++) begin
            cross_prod[i] = fix_t'(cross_wide[i] >>> Q_BITS);
        end
    end

endmodule

/* verilog/vec_elementwise.sv */
// Lane-wise vector add and scale of a vector by a fixed-point scalar
module vec_elementwise
    import vec_fixed_pkg::*;
(
    input  vec3_t        x,
    input  vec_operand_u y,
    output vec3_t        sum,
    output vec3_t        scaled
);

    logic signed [WIDE_BITS-1:0] prod [LANES];

    // Sums wrap at D_BITS
    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            sum[i] = x[i] + y.vec[i];
        end
    end

    // Scalar lives in the low word of y
    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            prod[i]   = wide_mul(x[i], y.scalar.value);
            scaled[i] = fix_t'(prod[i] >>> Q_BITS);
        end
    end

endmodule

/* verilog/sync_fifo.sv */
// Single-clock first-word-fall-through FIFO with full and empty flags
module sync_fifo #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 8
) (
    input  logic             clock,
    input  logic             reset,

    input  logic             wr_en,
    input  logic [WIDTH-1:0] din,
    output logic             full,

    input  logic             rd_en,
    output logic [WIDTH-1:0] dout,
    output logic             empty
);

    localparam int ADDR_BITS = $clog2(DEPTH);

    logic [WIDTH-1:0]   mem [DEPTH];

    // Extra top bit tells a full ring from an empty one
    logic [ADDR_BITS:0] wr_ptr;
    logic [ADDR_BITS:0] rd_ptr;
    logic               do_write;
    logic               do_read;

    assign do_write = wr_en && !full;
    assign do_read  = rd_en && !empty;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[ADDR_BITS] != rd_ptr[ADDR_BITS])
                && (wr_ptr[ADDR_BITS-1:0] == rd_ptr[ADDR_BITS-1:0]);

    // Head entry is visible without a read
    assign dout = mem[rd_ptr[ADDR_BITS-1:0]];

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (do_write) begin
            mem[wr_ptr[ADDR_BITS-1:0]] <= din;
        end
    end

    // Producer must respect full
    a_no_overflow: assert property (
        @(posedge clock) disable iff (reset)
        !(wr_en && full)
    ) else $error("sync_fifo: write while full");

    // Consumer must respect empty
    a_no_underflow: assert property (
        @(posedge clock) disable iff (reset)
        !(rd_en && empty)
    ) else $error("sync_fifo: read while empty");

endmodule

/* verilog/vec_cmd_pkg.sv */
// Command encoding and queue sizing for the vector arithmetic unit
package vec_cmd_pkg;

    // Operation selected by a command
    typedef enum logic [1:0] {
        OP_ADD   = 2'd0,
        OP_SCALE = 2'd1,
        OP_DOT   = 2'd2,
        OP_CROSS = 2'd3
    } vec_op_e;

    // Opcode above x above y
    localparam int CMD_BITS = $bits(vec_op_e)
                            + 2 * vec_fixed_pkg::LANES * vec_fixed_pkg::D_BITS;

    localparam int CMD_FIFO_DEPTH = 8;
    localparam int RES_FIFO_DEPTH = 8;

endpackage

/* verilog/vec_fixed_pkg.sv */
// Fixed-point number and 3-vector types shared by the vector arithmetic unit
package vec_fixed_pkg;

    localparam int D_BITS    = 32;
    localparam int Q_BITS    = 16;
    localparam int LANES     = 3;
    localparam int WIDE_BITS = 64;

    // Signed Q16.16 number
    typedef logic signed [D_BITS-1:0] fix_t;

    // Lane 0 sits in the low bits
    typedef fix_t [LANES-1:0] vec3_t;

    // Second operand and result word, read either as a vector or as one scalar
    typedef union packed {
        vec3_t vec;
        struct packed {
            logic [(LANES-1)*D_BITS-1:0] reserved;
            fix_t                        value;
        } scalar;
    } vec_operand_u;

    // Full-width signed product, before the fraction shift
    function automatic logic signed [WIDE_BITS-1:0] wide_mul(
        input fix_t a,
        input fix_t b
    );
        logic signed [WIDE_BITS-1:0] a_wide;
        logic signed [WIDE_BITS-1:0] b_wide;
        a_wide = WIDE_BITS'(a);
        b_wide = WIDE_BITS'(b);
        return a_wide * b_wide;
    endfunction

endpackage
